/* Bender.yml */
package:
  name: rasterizer

sources:
  - files:
      - hdl/rasterPkg.sv
      - hdl/triangleIf.sv
      - hdl/edgeStepIf.sv
      - hdl/triangleLoader.sv
      - hdl/edgeFunctions.sv
      - hdl/edgeWalker.sv
      - hdl/fragmentOut.sv
      - hdl/rasterizer.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rasterizerTb.sv

/* bench/rasterizerTriangles.svh */
// Test triangle table, packet builder and reference pixel coverage
`ifndef RASTERIZER_TRIANGLES_SVH
`define RASTERIZER_TRIANGLES_SVH

typedef wordT packetT [triangleWords];

localparam int triangleCount = 6;

// Vertices as x0, y0, x1, y1, x2, y2
// The last triangle reaches past the bottom screen row
localparam int vertexTable [triangleCount][6] = '{
    '{10, 10, 30, 14, 16, 28},
    '{60, 5, 40, 30, 75, 25},
    '{20, 40, 50, 45, 30, 70},
    '{5, 60, 45, 62, 20, 90},
    '{80, 70, 110, 80, 90, 100},
    '{50, 110, 90, 115, 70, 135}
};

// Box is the vertex hull, end exclusive, edges oriented so the inside is non-negative
function automatic packetT buildPacket(int index);
    int vx [3];
    int vy [3];
    int minX;
    int minY;
    int maxX;
    int maxY;
    int a;
    int b;
    int j;
    int k;
    packetT p;
    for (int i = 0; i < 3; i++)
    begin
        vx[i] = vertexTable[index][2 * i];
        vy[i] = vertexTable[index][2 * i + 1];
    end
    minX = vx[0];
    maxX = vx[0];
    minY = vy[0];
    maxY = vy[0];
    for (int i = 1; i < 3; i++)
    begin
        minX = (vx[i] < minX) ? vx[i] : minX;
        maxX = (vx[i] > maxX) ? vx[i] : maxX;
        minY = (vy[i] < minY) ? vy[i] : minY;
        maxY = (vy[i] > maxY) ? vy[i] : maxY;
    end
    p[bbStartSlot] = {16'(minY), 16'(minX)};
    p[bbEndSlot] = {16'(maxY + 1), 16'(maxX + 1)};
    for (int i = 0; i < 3; i++)
    begin
        j = (i + 1) % 3;
        k = (i + 2) % 3;
        a = vy[j] - vy[i];
        b = vx[i] - vx[j];
        // Flip the edge when the opposite vertex lands on the negative side
        if (a * (vx[k] - vx[i]) + b * (vy[k] - vy[i]) < 0)
        begin
            a = -a;
            b = -b;
        end
        p[w0Slot + i] = a * (minX - vx[i]) + b * (minY - vy[i]);
        p[w0XSlot + i] = a;
        p[w0YSlot + i] = b;
    end
    return p;
endfunction

// Edge value at a pixel from the packet words alone
function automatic int edgeValue(packetT p, int e, int x, int y);
    int dx;
    int dy;
    dx = x - int'(p[bbStartSlot][15:0]);
    dy = y - int'(p[bbStartSlot][31:16]);
    return $signed(p[w0Slot + e]) + dx * $signed(p[w0XSlot + e])
        + dy * $signed(p[w0YSlot + e]);
endfunction

function automatic bit pixelCovered(packetT p, int x, int y, int yRes);
    bit inBox;
    inBox = (x >= int'(p[bbStartSlot][15:0])) && (x < int'(p[bbEndSlot][15:0]))
        && (y >= int'(p[bbStartSlot][31:16])) && (y < int'(p[bbEndSlot][31:16]))
        && (y < yRes);
    return inBox && (edgeValue(p, 0, x, y) >= 0) && (edgeValue(p, 1, x, y) >= 0)
        && (edgeValue(p, 2, x, y) >= 0);
endfunction

function automatic int referenceCoverage(packetT p, int yRes);
    int count;
    count = 0;
    for (int y = int'(p[bbStartSlot][31:16]); y < int'(p[bbEndSlot][31:16]); y++)
    begin
        for (int x = int'(p[bbStartSlot][15:0]); x < int'(p[bbEndSlot][15:0]); x++)
        begin
            count += pixelCovered(p, x, y, yRes);
        end
    end
    return count;
endfunction

function automatic int boxArea(packetT p);
    return (int'(p[bbEndSlot][15:0]) - int'(p[bbStartSlot][15:0]))
        * (int'(p[bbEndSlot][31:16]) - int'(p[bbStartSlot][31:16]));
endfunction

`endif

/* bench/rasterizerTb.sv */
// Testbench for the rasterizer core
// Clock, reset, packet stimulus, fragment scoreboard, checks and watchdog
`timescale 1ns/1ps

module rasterizerTb import rasterPkg::*; ();

    localparam int clockPeriod = 100;
    localparam int xResolution = 128;
    localparam int yResolution = 128;

    logic clk;
    logic reset;
    logic triangleValid;
    logic triangleReady;
    logic triangleLast;
    wordT triangleData;
    logic fragmentValid;
    logic fragmentReady;
    fbIndexT fragmentIndex;
    coordT fragmentX;
    coordT fragmentY;
    logic running;

    `include "rasterizerTriangles.svh"

    packetT sentPackets [$];
    bit seen [int];
    int walkIndex = -1;
    int completed = 0;
    int fragmentCount = 0;
    int resetEdges = 0;
    int postResetEdges = 0;
    bit lastRunning = 0;
    bit randomReady = 0;
    // Back-pressure bookkeeping for the stall check
    bit holdPending = 0;
    fbIndexT heldIndex;
    coordT heldX;
    coordT heldY;
    // Set when a packet completes while another triangle walks
    bit readyHeld = 0;
    bit lastAcceptRunning = 0;

    rasterizer DUT
    (
        .clk           (clk),
        .reset         (reset),
        .triangleValid (triangleValid),
        .triangleReady (triangleReady),
        .triangleLast  (triangleLast),
        .triangleData  (triangleData),
        .fragmentValid (fragmentValid),
        .fragmentReady (fragmentReady),
        .fragmentIndex (fragmentIndex),
        .fragmentX     (fragmentX),
        .fragmentY     (fragmentY),
        .running       (running)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(clockPeriod / 2) clk = ~clk;

    task automatic failCheck(string message);
        $display("%s", message);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Sink readiness changes a little after each edge
    always @(posedge clk)
    begin
        #1;
        fragmentReady = randomReady ? ($urandom_range(3) != 0) : 1'b1;
    end

    // All checks sample the values from before the edge
    always @(posedge clk)
    begin
        if (reset)
        begin
            resetEdges++;
            postResetEdges = 0;
            if (resetEdges > 1)
            begin
                assert (!fragmentValid) else failCheck($sformatf(
                    "ERROR fragmentValid in reset: got %h expected %h", fragmentValid, 1'b0));
                assert (!running) else failCheck($sformatf(
                    "ERROR running in reset: got %h expected %h", running, 1'b0));
                assert (!triangleReady) else failCheck($sformatf(
                    "ERROR triangleReady in reset: got %h expected %h", triangleReady, 1'b0));
            end
        end
        else
        begin
            postResetEdges++;
            // Edge one shows the last reset edge and edge two the first edge out of reset
            if (postResetEdges <= 2)
            begin
                assert (!fragmentValid && !running) else failCheck($sformatf(
                    "ERROR fragmentValid/running after reset: got %h/%h expected 0/0",
                    fragmentValid, running));
            end
            if (postResetEdges == 1)
            begin
                assert (!triangleReady) else failCheck($sformatf(
                    "ERROR triangleReady in reset: got %h expected %h", triangleReady, 1'b0));
            end
            if (postResetEdges == 2)
            begin
                assert (triangleReady) else failCheck($sformatf(
                    "ERROR triangleReady after reset: got %h expected %h",
                    triangleReady, 1'b1));
            end

            if (running && !lastRunning)
            begin
                walkIndex++;
                fragmentCount = 0;
                seen.delete();
            end

            if (fragmentValid)
            begin
                assert (fragmentIndex == fbIndexT'((yResolution - 1 - int'(fragmentY))
                    * xResolution + int'(fragmentX))) else failCheck($sformatf(
                    "ERROR fragmentIndex: got %h expected %h", fragmentIndex,
                    fbIndexT'((yResolution - 1 - int'(fragmentY)) * xResolution
                    + int'(fragmentX))));
            end

            // Stalled fragment must not move
            if (holdPending)
            begin
                assert (fragmentValid) else failCheck($sformatf(
                    "ERROR fragmentValid under stall: got %h expected %h",
                    fragmentValid, 1'b1));
                assert (fragmentIndex == heldIndex && fragmentX == heldX && fragmentY == heldY)
                    else failCheck($sformatf(
                    "ERROR fragmentIndex/X/Y under stall: got %h/%h/%h expected %h/%h/%h",
                    fragmentIndex, fragmentX, fragmentY, heldIndex, heldX, heldY));
            end
            holdPending = fragmentValid && !fragmentReady;
            heldIndex = fragmentIndex;
            heldX = fragmentX;
            heldY = fragmentY;

            if (fragmentValid && fragmentReady)
            begin
                assert (walkIndex >= 0) else failCheck("Fragment arrived before any triangle");
                assert (fragmentY < yResolution) else failCheck($sformatf(
                    "ERROR fragmentY: got %h expected below %h", fragmentY, yResolution));
                assert (pixelCovered(sentPackets[walkIndex], fragmentX, fragmentY, yResolution))
                    else failCheck($sformatf(
                    "ERROR fragmentX/fragmentY: got %h/%h outside triangle",
                    fragmentX, fragmentY));
                assert (!seen.exists(int'(fragmentY) * 65536 + int'(fragmentX)))
                    else failCheck($sformatf(
                    "ERROR fragmentX/fragmentY: got %h/%h a second time",
                    fragmentX, fragmentY));
                seen[int'(fragmentY) * 65536 + int'(fragmentX)] = 1'b1;
                fragmentCount++;
            end

            // Loader stays full until the walking triangle ends
            if (readyHeld && running)
            begin
                assert (!triangleReady) else failCheck($sformatf(
                    "ERROR triangleReady while full: got %h expected %h",
                    triangleReady, 1'b0));
            end
            if (triangleValid && triangleReady && triangleLast)
            begin
                lastAcceptRunning = running;
                readyHeld = running;
            end

            if (!running && lastRunning)
            begin
                assert (fragmentCount == referenceCoverage(sentPackets[walkIndex], yResolution))
                    else failCheck($sformatf("ERROR fragment count: got %h expected %h",
                    fragmentCount, referenceCoverage(sentPackets[walkIndex], yResolution)));
                readyHeld = 1'b0;
                completed++;
            end
            lastRunning = running;
        end
    end

    // Words go out with random gaps and each one waits until the loader takes it
    task automatic sendPacket(packetT p);
        int gap;
        sentPackets.push_back(p);
        for (int i = 0; i < triangleWords; i++)
        begin
            gap = $urandom_range(1);
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
            triangleValid = 1'b1;
            triangleData = p[i];
            triangleLast = (i == triangleWords - 1);
            do
            begin
                @(posedge clk);
            end
            while (!triangleReady);
            #1;
            triangleValid = 1'b0;
            triangleLast = 1'b0;
        end
    endtask

    task automatic waitForTriangles(int count);
        wait (completed >= count);
        @(posedge clk);
        #1;
    endtask

    // Generous bound from box sizes and packet lengths
    initial
    begin
        int limit;
        limit = 40;
        for (int i = 0; i < triangleCount; i++)
        begin
            limit += boxArea(buildPacket(i)) * 4 + triangleWords * 4;
        end
        #(limit * clockPeriod);
        failCheck("Timeout: the rasterizer did not finish all triangles in time");
    end

    initial
    begin
        void'($urandom(32'h15fb_515e));
        reset = 1'b1;
        triangleValid = 1'b0;
        triangleLast = 1'b0;
        triangleData = '0;
        fragmentReady = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        // Free-running sink with one triangle at a time
        sendPacket(buildPacket(0));
        waitForTriangles(1);
        sendPacket(buildPacket(1));
        waitForTriangles(2);

        // Random back-pressure
        randomReady = 1'b1;
        sendPacket(buildPacket(2));
        waitForTriangles(3);

        // Second packet while the first one walks
        sendPacket(buildPacket(3));
        wait (running);
        @(posedge clk);
        #1;
        sendPacket(buildPacket(4));
        assert (lastAcceptRunning) else
            failCheck("The second packet was not accepted while the first triangle walked");
        waitForTriangles(5);

        // Box reaching past the bottom of the screen
        randomReady = 1'b0;
        sendPacket(buildPacket(5));
        waitForTriangles(6);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* hdl/edgeFunctions.sv */
// Edge-function unit
// Three accumulators stepped by pixel and by line, plus the inside test
`timescale 1ns/1ps

module edgeFunctions import rasterPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    triangleIf.edges triangle,
    edgeStepIf.edges step
);

    edgeT [edgeCount-1:0] acc;
    edgeT [edgeCount-1:0] incX;
    edgeT [edgeCount-1:0] incY;
    logic [edgeCount-1:0] nonNegative;
    // Set once a triangle has been copied in
    logic armed;

    // A pixel is inside when no edge function has its sign bit set
    always_comb
    begin
        for (int i = 0; i < edgeCount; i++)
        begin
            nonNegative[i] = !acc[i][31];
        end
    end

    // Nothing counts as inside before the first triangle arrives
    assign step.isInside = armed & (&nonNegative);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            armed <= 1'b0;
        end
        else if (step.load)
        begin
            armed <= 1'b1;
        end
    end

    // The walker never asks for a line step and a pixel step together
    always_ff @(posedge clk)
    begin
        if (step.load)
        begin
            acc <= triangle.w;
            incX <= triangle.wX;
            incY <= triangle.wY;
        end
        else
        begin
            for (int i = 0; i < edgeCount; i++)
            begin
                if (step.lineStep)
                begin
                    acc[i] <= acc[i] + incY[i];
                end
                else if (step.advance)
                begin
                    // Walking left undoes the x increment
                    if (step.dir == dirRight)
                    begin
                        acc[i] <= acc[i] + incX[i];
                    end
                    else
                    begin
                        acc[i] <= acc[i] - incX[i];
                    end
                end
            end
        end
    end

endmodule

/* hdl/edgeStepIf.sv */
// Step commands from the walker and the inside test from the edge unit
`timescale 1ns/1ps

interface edgeStepIf import rasterPkg::*; ();

    // Copy a fresh triangle into the accumulators
    logic load;
    // Pixel step in the direction given by dir
    logic advance;
    // Line step, one row down
    logic lineStep;
    walkDirT dir;
    // All three edge functions are non-negative at the current position
    logic isInside;

    modport walker
    (
        output load, advance, lineStep, dir,
        input  isInside
    );

    modport edges
    (
        input  load, advance, lineStep, dir,
        output isInside
    );

endinterface

/* hdl/edgeWalker.sv */
// Raster FSM and zig-zag edge walker
// Keeps the x/y position, walk direction and the latched bounding box
`timescale 1ns/1ps

module edgeWalker import rasterPkg::*;
#(
    parameter int yResolution = 128
)
(
    input  logic      clk,
    input  logic      reset,
    triangleIf.walker triangle,
    edgeStepIf.walker step,
    input  logic      fragmentReady,
    output logic      running,
    output logic      hit,
    output coordT     x,
    output coordT     y
);

    rasterStateT rasterState;
    walkStateT walkState;
    walkDirT dir;
    // Set after one box edge was reached without finding the triangle
    logic tryOtherSide;
    logic takePending;

    coordT boxStartX;
    coordT boxStartY;
    coordT boxEndX;
    coordT boxEndY;

    logic active;
    logic inRange;
    logic inBox;
    logic inTriangleAndBox;
    logic emitState;
    logic lineStep;

    // Every walk step waits for the fragment sink, otherwise all state holds
    assign active = (rasterState == rasterWalk) & fragmentReady;

    // Rows at or past the box end or the screen bottom end the walk
    assign inRange = (y < boxEndY) && (y < yResolution);
    // The box end is exclusive
    assign inBox = (x >= boxStartX) && (x < boxEndX);
    assign inTriangleAndBox = step.isInside & inBox;

    // Only these states shade the pixel they stand on
    assign emitState = (walkState == walkStart) | (walkState == walkSearchEdge)
        | (walkState == walkWalk);
    assign hit = (rasterState == rasterWalk) & inRange & emitState & inTriangleAndBox;

    // Leaving the triangle while walking moves one row down.
    // The direction check spends a cycle without any step
    assign lineStep = active & (walkState == walkWalk) & !inTriangleAndBox;

    assign step.lineStep = lineStep;
    assign step.advance = active & (walkState != walkCheckDir) & !lineStep;
    assign step.dir = dir;
    assign step.load = takePending;
    assign triangle.take = takePending;

    // Private copy of the box so that the loader can refill at once
    always_ff @(posedge clk)
    begin
        if (takePending)
        begin
            boxStartX <= boxX(triangle.bbStart);
            boxStartY <= boxY(triangle.bbStart);
            boxEndX <= boxX(triangle.bbEnd);
            boxEndY <= boxY(triangle.bbEnd);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rasterState <= rasterIdle;
            walkState <= walkStart;
            dir <= dirRight;
            tryOtherSide <= 1'b0;
            takePending <= 1'b0;
            running <= 1'b0;
            x <= '0;
            y <= '0;
        end
        else
        begin
            case (rasterState)
                rasterIdle:
                begin
                    // Take is raised one cycle after a loaded triangle shows up
                    if (takePending)
                    begin
                        takePending <= 1'b0;
                        running <= 1'b1;
                        rasterState <= rasterInit;
                    end
                    else if (triangle.loaded)
                    begin
                        takePending <= 1'b1;
                    end
                end

                rasterInit:
                begin
                    x <= boxStartX;
                    y <= boxStartY;
                    dir <= dirRight;
                    tryOtherSide <= 1'b0;
                    walkState <= walkStart;
                    rasterState <= rasterWalk;
                end

                rasterWalk:
                begin
                    if (fragmentReady)
                    begin
                        // Position follows the same step the accumulators take
                        if (lineStep)
                        begin
                            y <= y + coordT'(1);
                        end
                        else if (step.advance)
                        begin
                            x <= (dir == dirRight) ? x + coordT'(1) : x - coordT'(1);
                        end

                        if (inRange)
                        begin
                            case (walkState)
                                walkStart:
                                begin
                                    walkState <= inTriangleAndBox ? walkWalk : walkSearchEdge;
                                end

                                walkCheckDir:
                                begin
                                    // Inside after the line step means the edge lies ahead
                                    if (step.isInside)
                                    begin
                                        walkState <= walkWalkOut;
                                    end
                                    else
                                    begin
                                        // Most likely the triangle is behind us
                                        dir <= (dir == dirRight) ? dirLeft : dirRight;
                                        walkState <= walkSearchEdge;
                                    end
                                end

                                walkSearchEdge:
                                begin
                                    if (inTriangleAndBox)
                                    begin
                                        tryOtherSide <= 1'b0;
                                        walkState <= walkWalk;
                                    end
                                    else if (x == boxEndX)
                                    begin
                                        // Both sides searched, so the row is empty
                                        if ((dir == dirRight) && tryOtherSide)
                                        begin
                                            tryOtherSide <= 1'b0;
                                            walkState <= walkWalk;
                                        end
                                        else
                                        begin
                                            tryOtherSide <= 1'b1;
                                            dir <= dirLeft;
                                        end
                                    end
                                    else if (x == boxStartX)
                                    begin
                                        // Same retry at the left edge of the box
                                        if ((dir == dirLeft) && tryOtherSide)
                                        begin
                                            tryOtherSide <= 1'b0;
                                            walkState <= walkWalk;
                                        end
                                        else
                                        begin
                                            tryOtherSide <= 1'b1;
                                            dir <= dirRight;
                                        end
                                    end
                                end

                                walkWalkOut:
                                begin
                                    // Skip to the far edge, then turn and shade back
                                    if (!step.isInside || (x == boxStartX) || (x >= boxEndX))
                                    begin
                                        dir <= (dir == dirRight) ? dirLeft : dirRight;
                                        walkState <= walkSearchEdge;
                                    end
                                end

                                walkWalk:
                                begin
                                    if (!inTriangleAndBox)
                                    begin
                                        walkState <= walkCheckDir;
                                    end
                                end

                                default:
                                begin
                                    walkState <= walkStart;
                                end
                            endcase
                        end
                        else
                        begin
                            // Below the box or the screen, nothing more to hit
                            running <= 1'b0;
                            rasterState <= rasterIdle;
                        end
                    end
                end

                default:
                begin
                    rasterState <= rasterIdle;
                end
            endcase
        end
    end

endmodule

/* hdl/fragmentOut.sv */
// Fragment output register
// Holds the fragment under back-pressure and computes its framebuffer index
`timescale 1ns/1ps

module fragmentOut import rasterPkg::*;
#(
    parameter int xResolution = 128,
    parameter int yResolution = 128
)
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fragmentReady,
    input  logic    running,
    input  logic    hit,
    input  coordT   x,
    input  coordT   y,
    output logic    fragmentValid,
    output fbIndexT fragmentIndex,
    output coordT   fragmentX,
    output coordT   fragmentY
);

    fbIndexT flippedRow;
    fbIndexT pixelIndex;

    // The framebuffer stores the bottom row first
    assign flippedRow = fbIndexT'(yResolution - 1) - fbIndexT'(y);
    assign pixelIndex = fbIndexT'(flippedRow * fbIndexT'(xResolution)) + fbIndexT'(x);

    // Loading only on ready keeps a pending fragment stable until accepted
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fragmentValid <= 1'b0;
        end
        else if (fragmentReady)
        begin
            fragmentValid <= hit & running;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fragmentReady)
        begin
            fragmentIndex <= pixelIndex;
            fragmentX <= x;
            fragmentY <= y;
        end
    end

endmodule

/* hdl/rasterPkg.sv */
// Shared types for the rasterizer core
// Packet slot layout, vector typedefs, FSM enums and box field helpers
package rasterPkg;

    // One 32-bit word of the triangle stream
    typedef logic [31:0] wordT;
    // Edge-function values and increments are two's complement
    typedef logic signed [31:0] edgeT;
    // Screen coordinate, one half of a bounding box word
    typedef logic [15:0] coordT;
    typedef logic [15:0] fbIndexT;
    // Wide enough to count one past the last packet slot
    typedef logic [3:0] slotT;

    localparam int triangleWords = 11;
    localparam int edgeCount = 3;

    // Packet word order
    localparam int bbStartSlot = 0;
    localparam int bbEndSlot = 1;
    localparam int w0Slot = 2;
    localparam int w1Slot = 3;
    localparam int w2Slot = 4;
    localparam int w0XSlot = 5;
    localparam int w1XSlot = 6;
    localparam int w2XSlot = 7;
    localparam int w0YSlot = 8;
    localparam int w1YSlot = 9;
    localparam int w2YSlot = 10;

    typedef enum logic [1:0]
    {
        rasterIdle,
        rasterInit,
        rasterWalk
    } rasterStateT;

    typedef enum logic [2:0]
    {
        walkStart,
        walkSearchEdge,
        walkWalkOut,
        walkWalk,
        walkCheckDir
    } walkStateT;

    typedef enum logic
    {
        dirLeft,
        dirRight
    } walkDirT;

    // A box word holds y in the upper half and x in the lower half
    function automatic coordT boxX(wordT word);
        return word[15:0];
    endfunction

    function automatic coordT boxY(wordT word);
        return word[31:16];
    endfunction

endpackage

/* hdl/rasterizer.sv */
// Rasterizer core top level
// Loader, edge-function unit, edge walker and fragment output stage
`timescale 1ns/1ps

module rasterizer import rasterPkg::*;
#(
    parameter int xResolution = 128,
    parameter int yResolution = 128
)
(
    input  logic    clk,
    input  logic    reset,

    // Triangle packet stream
    input  logic    triangleValid,
    output logic    triangleReady,
    input  logic    triangleLast,
    input  wordT    triangleData,

    // Fragment stream
    output logic    fragmentValid,
    input  logic    fragmentReady,
    output fbIndexT fragmentIndex,
    output coordT   fragmentX,
    output coordT   fragmentY,

    // High while a triangle is being walked
    output logic    running
);

    triangleIf triangle ();
    edgeStepIf step ();

    logic hit;
    coordT x;
    coordT y;

    triangleLoader loader
    (
        .clk           (clk),
        .reset         (reset),
        .triangleValid (triangleValid),
        .triangleReady (triangleReady),
        .triangleLast  (triangleLast),
        .triangleData  (triangleData),
        .triangle      (triangle.loader)
    );

    edgeFunctions edges
    (
        .clk      (clk),
        .reset    (reset),
        .triangle (triangle.edges),
        .step     (step.edges)
    );

    edgeWalker #(
        .yResolution (yResolution)
    ) walker (
        .clk           (clk),
        .reset         (reset),
        .triangle      (triangle.walker),
        .step          (step.walker),
        .fragmentReady (fragmentReady),
        .running       (running),
        .hit           (hit),
        .x             (x),
        .y             (y)
    );

    fragmentOut #(
        .xResolution (xResolution),
        .yResolution (yResolution)
    ) output0 (
        .clk           (clk),
        .reset         (reset),
        .fragmentReady (fragmentReady),
        .running       (running),
        .hit           (hit),
        .x             (x),
        .y             (y),
        .fragmentValid (fragmentValid),
        .fragmentIndex (fragmentIndex),
        .fragmentX     (fragmentX),
        .fragmentY     (fragmentY)
    );

endmodule

/* hdl/triangleIf.sv */
// Loaded triangle record passed from the loader to the walker and edge unit
`timescale 1ns/1ps

interface triangleIf import rasterPkg::*; ();

    // High while a complete triangle waits in the loader
    logic loaded;
    // One-cycle pulse from the walker, both consumers copy the record on it
    logic take;

    wordT bbStart;
    wordT bbEnd;
    // Start values and per-pixel and per-line increments of the three edges
    edgeT [edgeCount-1:0] w;
    edgeT [edgeCount-1:0] wX;
    edgeT [edgeCount-1:0] wY;

    modport loader
    (
        output loaded, bbStart, bbEnd, w, wX, wY,
        input  take
    );

    modport walker
    (
        input  loaded, bbStart, bbEnd,
        output take
    );

    // The edge unit copies on the walker's load command
    modport edges
    (
        input w, wX, wY
    );

endinterface

/* hdl/triangleLoader.sv */
// Triangle packet loader
// Stores stream words by slot and offers the finished record to the walker
`timescale 1ns/1ps

module triangleLoader import rasterPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      triangleValid,
    output logic      triangleReady,
    input  logic      triangleLast,
    input  wordT      triangleData,
    triangleIf.loader triangle
);

    wordT words [triangleWords];
    slotT slotIndex;
    logic accept;
    logic loadedNext;

    assign accept = triangleValid & triangleReady;

    // A record becomes loaded with its last word and is released by take.
    // Ready is never high while loaded, so both cannot happen at once
    always_comb
    begin
        loadedNext = triangle.loaded;
        if (accept & triangleLast)
        begin
            loadedNext = 1'b1;
        end
        else if (triangle.take)
        begin
            loadedNext = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slotIndex <= '0;
            triangle.loaded <= 1'b0;
            triangleReady <= 1'b0;
        end
        else
        begin
            triangle.loaded <= loadedNext;
            // Registered so that ready stays low through reset
            triangleReady <= !loadedNext;
            if (accept)
            begin
                if (triangleLast)
                begin
                    slotIndex <= '0;
                end
                else if (slotIndex < triangleWords)
                begin
                    slotIndex <= slotIndex + slotT'(1);
                end
            end
        end
    end

    // Words beyond the last slot are accepted but not stored
    always_ff @(posedge clk)
    begin
        if (accept && (slotIndex < triangleWords))
        begin
            words[slotIndex] <= triangleData;
        end
    end

    assign triangle.bbStart = words[bbStartSlot];
    assign triangle.bbEnd = words[bbEndSlot];
    assign triangle.w = {words[w2Slot], words[w1Slot], words[w0Slot]};
    assign triangle.wX = {words[w2XSlot], words[w1XSlot], words[w0XSlot]};
    assign triangle.wY = {words[w2YSlot], words[w1YSlot], words[w0YSlot]};

endmodule

/* rasterizer.f */
+incdir+bench
hdl/rasterPkg.sv
hdl/triangleIf.sv
hdl/edgeStepIf.sv
hdl/triangleLoader.sv
hdl/edgeFunctions.sv
hdl/edgeWalker.sv
hdl/fragmentOut.sv
hdl/rasterizer.sv
bench/rasterizerTb.sv
